// ==== rx_sync.f ====
+incdir+include
logic/rx_sync_pkg.sv
logic/rx_axil_pkg.sv
logic/cfo_phase_tracker.sv
logic/detect_capture.sv
logic/rx_regmap.sv
logic/rx_sync_top.sv
dv/rx_sync_tb.sv

// ==== Makefile ====
# Verilator build for the rx_sync testbench
# override any variable on the command line, e.g. make run TOP=rx_sync_tb

VERILATOR ?= verilator
TOP       ?= rx_sync_tb
FLIST     ?= rx_sync.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0
EXTRA     ?=

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard include/*.svh logic/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FLIST) $(EXTRA)

# exit status of the simulation is the pass/fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/rx_sync_tb.sv ====
`default_nettype none

`include "rx_sync_defs.svh"

module rx_sync_tb
    import rx_sync_pkg::*;
    import rx_axil_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int N_ROWS         = 47;

    typedef enum logic [2:0] {
        K_SAMPLE, K_CFO, K_NID2, K_NID, K_IBAR, K_WRITE, K_READ
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [31:0] value;
        axil_addr_t  addr;
        axil_data_t  exp;
    } row_t;

    // --------------------------------------------------
    // stimulus table with hand-worked expected reads
    // --------------------------------------------------
    localparam row_t STIM [N_ROWS] = '{
        // reset state
        '{K_READ,   32'h0,         `RX_REG_ID,     `RX_ID},
        '{K_READ,   32'h0,         `RX_REG_CTRL,   32'h0},
        '{K_READ,   32'h0,         `RX_REG_SAMPLE, 32'h0},
        '{K_READ,   32'h0,         `RX_REG_PHASE,  32'h0},
        '{K_READ,   32'h0,         `RX_REG_INC,    32'h0},
        '{K_READ,   32'h0,         `RX_REG_NID2,   32'h0},
        '{K_READ,   32'h0,         `RX_REG_NID,    32'h0},
        '{K_READ,   32'h0,         `RX_REG_IBAR,   32'h0},
        // accumulation gives inc -5 then -3
        '{K_CFO,    32'h5,         8'h00,          32'h0},
        '{K_READ,   32'h0,         `RX_REG_INC,    32'hFFFF_FFFB},
        '{K_SAMPLE, 32'h1111_2222, 8'h00,          32'h0},
        '{K_SAMPLE, 32'h3333_4444, 8'h00,          32'h0},
        '{K_SAMPLE, 32'h5555_6666, 8'h00,          32'h0},
        '{K_READ,   32'h0,         `RX_REG_PHASE,  32'hFFFF_FFF1},
        '{K_CFO,    32'hFFFF_FFFE, 8'h00,          32'h0},
        '{K_READ,   32'h0,         `RX_REG_INC,    32'hFFFF_FFFD},
        '{K_SAMPLE, 32'h7777_8888, 8'h00,          32'h0},
        '{K_SAMPLE, 32'h9999_AAAA, 8'h00,          32'h0},
        '{K_READ,   32'h0,         `RX_REG_PHASE,  32'hFFFF_FFEB},
        '{K_READ,   32'h0,         `RX_REG_SAMPLE, 32'h9999_AAAA},
        // manual mode parks the oscillator
        '{K_WRITE,  32'h1,         `RX_REG_CTRL,   32'h0},
        '{K_READ,   32'h0,         `RX_REG_CTRL,   32'h1},
        '{K_READ,   32'h0,         `RX_REG_PHASE,  32'h0},
        '{K_READ,   32'h0,         `RX_REG_INC,    32'h0},
        '{K_CFO,    32'h7,         8'h00,          32'h0},
        '{K_SAMPLE, 32'h0BAD_F00D, 8'h00,          32'h0},
        '{K_READ,   32'h0,         `RX_REG_INC,    32'h0},
        '{K_READ,   32'h0,         `RX_REG_PHASE,  32'h0},
        '{K_READ,   32'h0,         `RX_REG_SAMPLE, 32'h0BAD_F00D},
        '{K_WRITE,  32'h0,         `RX_REG_CTRL,   32'h0},
        '{K_CFO,    32'h4,         8'h00,          32'h0},
        '{K_SAMPLE, 32'h0000_0001, 8'h00,          32'h0},
        '{K_READ,   32'h0,         `RX_REG_INC,    32'hFFFF_FFFC},
        '{K_READ,   32'h0,         `RX_REG_PHASE,  32'hFFFF_FFFC},
        // detections
        '{K_NID2,   32'h1,         8'h00,          32'h0},
        '{K_NID2,   32'h2,         8'h00,          32'h0},
        '{K_NID,    32'h3A7,       8'h00,          32'h0},
        '{K_IBAR,   32'h5,         8'h00,          32'h0},
        '{K_IBAR,   32'h6,         8'h00,          32'h0},
        '{K_IBAR,   32'h7,         8'h00,          32'h0},
        '{K_READ,   32'h0,         `RX_REG_NID2,   32'h0002_0002},
        '{K_READ,   32'h0,         `RX_REG_NID,    32'h0001_03A7},
        '{K_READ,   32'h0,         `RX_REG_IBAR,   32'h0003_0007},
        // unmapped and read-only
        '{K_READ,   32'h0,         8'h40,          32'h0},
        '{K_READ,   32'h0,         8'h28,          32'h0},
        '{K_WRITE,  32'h1235,      `RX_REG_PHASE,  32'h0},
        '{K_READ,   32'h0,         `RX_REG_PHASE,  32'hFFFF_FFFC}
    };

    logic       clk_i;
    logic       reset_ni;
    sample_t    sample_i;
    logic       sample_valid_i;
    phase_t     cfo_inc_i;
    logic       cfo_valid_i;
    n_id_2_t    n_id_2_i;
    logic       n_id_2_valid_i;
    n_id_t      n_id_i;
    logic       n_id_valid_i;
    ibar_t      ibar_i;
    logic       ibar_valid_i;
    axil_addr_t s_axil_awaddr_i;
    logic       s_axil_awvalid_i;
    logic       s_axil_awready_o;
    axil_data_t s_axil_wdata_i;
    axil_strb_t s_axil_wstrb_i;
    logic       s_axil_wvalid_i;
    logic       s_axil_wready_o;
    axil_resp_t s_axil_bresp_o;
    logic       s_axil_bvalid_o;
    logic       s_axil_bready_i;
    axil_addr_t s_axil_araddr_i;
    logic       s_axil_arvalid_i;
    logic       s_axil_arready_o;
    axil_data_t s_axil_rdata_o;
    axil_resp_t s_axil_rresp_o;
    logic       s_axil_rvalid_o;
    logic       s_axil_rready_i;

    rx_sync_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic axil_data_t sign_extend(input phase_t p);
        return {{(`RX_AXIL_DATA_W-`RX_PHASE_DW){p[`RX_PHASE_DW-1]}}, p};
    endfunction

    // --------------------------------------------------
    // bus tasks entered and left on a falling edge
    // --------------------------------------------------
    task automatic write_addr_data(input axil_addr_t addr, input axil_data_t data);
        int n;
        s_axil_awaddr_i  = addr;
        s_axil_wdata_i   = data;
        s_axil_awvalid_i = 1'b1;
        s_axil_wvalid_i  = 1'b1;
        n = 0;
        while (!s_axil_awready_o) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run("timeout: write address and data handshake did not complete");
            end
        end
        check_flag("s_axil_wready_o", s_axil_wready_o, 1'b1);
        @(posedge clk_i);
        @(negedge clk_i);
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i  = 1'b0;
    endtask

    task automatic wait_bresp();
        int n;
        n = 0;
        while (!s_axil_bvalid_o) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run("timeout: write response never arrived");
            end
        end
        check_resp("s_axil_bresp_o", s_axil_bresp_o, RESP_OKAY);
        @(negedge clk_i);
    endtask

    task automatic read_addr(input axil_addr_t addr);
        int n;
        s_axil_araddr_i  = addr;
        s_axil_arvalid_i = 1'b1;
        n = 0;
        while (!s_axil_arready_o) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run("timeout: read address handshake did not complete");
            end
        end
        @(posedge clk_i);
        @(negedge clk_i);
        s_axil_arvalid_i = 1'b0;
    endtask

    task automatic wait_rdata(input axil_data_t exp, input string name);
        int n;
        n = 0;
        while (!s_axil_rvalid_o) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run("timeout: read data never arrived");
            end
        end
        check_data(name, s_axil_rdata_o, exp);
        check_resp("s_axil_rresp_o", s_axil_rresp_o, RESP_OKAY);
        @(negedge clk_i);
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        write_addr_data(addr, data);
        wait_bresp();
    endtask

    task automatic axil_read(input axil_addr_t addr, input axil_data_t exp, input string name);
        read_addr(addr);
        wait_rdata(exp, name);
    endtask

    // one-cycle pulse on a signal-path input
    task automatic pulse(input kind_e kind, input logic [31:0] value);
        case (kind)
            K_SAMPLE: begin
                sample_i       = value;
                sample_valid_i = 1'b1;
            end
            K_CFO: begin
                cfo_inc_i   = value[`RX_PHASE_DW-1:0];
                cfo_valid_i = 1'b1;
            end
            K_NID2: begin
                n_id_2_i       = value[1:0];
                n_id_2_valid_i = 1'b1;
            end
            K_NID: begin
                n_id_i       = value[9:0];
                n_id_valid_i = 1'b1;
            end
            default: begin
                ibar_i       = value[2:0];
                ibar_valid_i = 1'b1;
            end
        endcase
        @(negedge clk_i);
        sample_valid_i = 1'b0;
        cfo_valid_i    = 1'b0;
        n_id_2_valid_i = 1'b0;
        n_id_valid_i   = 1'b0;
        ibar_valid_i   = 1'b0;
    endtask

    task automatic apply_row(input row_t r, input int idx);
        case (r.kind)
            K_WRITE: axil_write(r.addr, r.value);
            K_READ:  axil_read(r.addr, r.exp, $sformatf("s_axil_rdata_o row %0d", idx));
            default: pulse(r.kind, r.value);
        endcase
    endtask

    // --------------------------------------------------
    // back-pressure
    // --------------------------------------------------
    task automatic check_write_backpressure();
        s_axil_bready_i = 1'b0;
        write_addr_data(`RX_REG_CTRL, 32'h0);
        s_axil_awaddr_i  = `RX_REG_PHASE;
        s_axil_wdata_i   = 32'hDEAD_BEEF;
        s_axil_awvalid_i = 1'b1;
        s_axil_wvalid_i  = 1'b1;
        repeat (5) begin
            @(negedge clk_i);
            check_flag("s_axil_bvalid_o", s_axil_bvalid_o, 1'b1);
            check_flag("s_axil_awready_o", s_axil_awready_o, 1'b0);
            check_flag("s_axil_wready_o", s_axil_wready_o, 1'b0);
        end
        check_resp("s_axil_bresp_o", s_axil_bresp_o, RESP_OKAY);
        s_axil_bready_i = 1'b1;
        write_addr_data(`RX_REG_PHASE, 32'hDEAD_BEEF);
        wait_bresp();
    endtask

    task automatic check_read_backpressure();
        s_axil_rready_i = 1'b0;
        read_addr(`RX_REG_ID);
        s_axil_araddr_i  = `RX_REG_CTRL;
        s_axil_arvalid_i = 1'b1;
        repeat (5) begin
            @(negedge clk_i);
            check_flag("s_axil_rvalid_o", s_axil_rvalid_o, 1'b1);
            check_flag("s_axil_arready_o", s_axil_arready_o, 1'b0);
            check_data("s_axil_rdata_o held", s_axil_rdata_o, `RX_ID);
        end
        s_axil_rready_i = 1'b1;
        read_addr(`RX_REG_CTRL);
        wait_rdata(32'h0, "s_axil_rdata_o after release");
    endtask

    // --------------------------------------------------
    // random samples and corrections against the phase rule
    // --------------------------------------------------
    task automatic run_random_pass();
        logic [31:0] rng;
        logic [31:0] smp;
        phase_t      corr;
        phase_t      m_phase;
        phase_t      m_inc;
        sample_t     m_sample;
        logic        do_s;
        logic        do_c;
        rng = 32'd78;
        // toggle manual mode so the model starts from zero
        axil_write(`RX_REG_CTRL, 32'h1);
        axil_write(`RX_REG_CTRL, 32'h0);
        m_phase  = '0;
        m_inc    = '0;
        m_sample = '0;
        for (int i = 0; i < 48; i++) begin
            rng  = xorshift32(rng);
            smp  = rng;
            rng  = xorshift32(rng);
            corr = rng[`RX_PHASE_DW-1:0];
            do_s = rng[20] || (i == 0);
            do_c = rng[21];
            sample_i       = smp;
            sample_valid_i = do_s;
            cfo_inc_i      = corr;
            cfo_valid_i    = do_c;
            @(negedge clk_i);
            sample_valid_i = 1'b0;
            cfo_valid_i    = 1'b0;
            // phase advances by the increment from before this cycle
            if (do_s) begin
                m_phase  = m_phase + m_inc;
                m_sample = smp;
            end
            if (do_c) begin
                m_inc = m_inc - corr;
            end
            if (i % 8 == 7) begin
                axil_read(`RX_REG_PHASE, sign_extend(m_phase), "s_axil_rdata_o random phase");
                axil_read(`RX_REG_INC, sign_extend(m_inc), "s_axil_rdata_o random inc");
                axil_read(`RX_REG_SAMPLE, m_sample, "s_axil_rdata_o random sample");
            end
        end
    endtask

    initial begin
        reset_ni         = 1'b0;
        sample_i         = '0;
        sample_valid_i   = 1'b0;
        cfo_inc_i        = '0;
        cfo_valid_i      = 1'b0;
        n_id_2_i         = '0;
        n_id_2_valid_i   = 1'b0;
        n_id_i           = '0;
        n_id_valid_i     = 1'b0;
        ibar_i           = '0;
        ibar_valid_i     = 1'b0;
        s_axil_awaddr_i  = '0;
        s_axil_awvalid_i = 1'b0;
        s_axil_wdata_i   = '0;
        s_axil_wstrb_i   = '1;
        s_axil_wvalid_i  = 1'b0;
        s_axil_bready_i  = 1'b1;
        s_axil_araddr_i  = '0;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i  = 1'b1;
        repeat (10) @(negedge clk_i);
        reset_ni = 1'b1;

        for (int i = 0; i < N_ROWS; i++) begin
            apply_row(STIM[i], i);
        end
        check_write_backpressure();
        check_read_backpressure();
        run_random_pass();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/rx_sync_top.sv ====
`default_nettype none

module rx_sync_top
    import rx_sync_pkg::*;
    import rx_axil_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_ni,

    input  wire sample_t    sample_i,
    input  wire logic       sample_valid_i,
    input  wire phase_t     cfo_inc_i,
    input  wire logic       cfo_valid_i,

    input  wire n_id_2_t    n_id_2_i,
    input  wire logic       n_id_2_valid_i,
    input  wire n_id_t      n_id_i,
    input  wire logic       n_id_valid_i,
    input  wire ibar_t      ibar_i,
    input  wire logic       ibar_valid_i,

    input  wire axil_addr_t s_axil_awaddr_i,
    input  wire logic       s_axil_awvalid_i,
    output logic            s_axil_awready_o,
    input  wire axil_data_t s_axil_wdata_i,
    input  wire axil_strb_t s_axil_wstrb_i,
    input  wire logic       s_axil_wvalid_i,
    output logic            s_axil_wready_o,
    output axil_resp_t      s_axil_bresp_o,
    output logic            s_axil_bvalid_o,
    input  wire logic       s_axil_bready_i,
    input  wire axil_addr_t s_axil_araddr_i,
    input  wire logic       s_axil_arvalid_i,
    output logic            s_axil_arready_o,
    output axil_data_t      s_axil_rdata_o,
    output axil_resp_t      s_axil_rresp_o,
    output logic            s_axil_rvalid_o,
    input  wire logic       s_axil_rready_i
);

    logic    cfo_mode;
    phase_t  phase;
    phase_t  inc_acc;
    sample_t last_sample;
    n_id_2_t n_id_2_q;
    n_id_t   n_id_q;
    ibar_t   ibar_q;
    cnt_t    n_id_2_cnt;
    cnt_t    n_id_cnt;
    cnt_t    ibar_cnt;

    cfo_phase_tracker u_tracker (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_mode_i     (cfo_mode),
        .phase_o        (phase),
        .inc_acc_o      (inc_acc),
        .last_sample_o  (last_sample)
    );

    // --------------------------------------------------
    // detection captures
    // --------------------------------------------------
    detect_capture #(.payload_t(n_id_2_t)) u_cap_nid2 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .value_i  (n_id_2_i),
        .valid_i  (n_id_2_valid_i),
        .value_o  (n_id_2_q),
        .count_o  (n_id_2_cnt)
    );

    detect_capture #(.payload_t(n_id_t)) u_cap_nid (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .value_i  (n_id_i),
        .valid_i  (n_id_valid_i),
        .value_o  (n_id_q),
        .count_o  (n_id_cnt)
    );

    detect_capture #(.payload_t(ibar_t)) u_cap_ibar (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .value_i  (ibar_i),
        .valid_i  (ibar_valid_i),
        .value_o  (ibar_q),
        .count_o  (ibar_cnt)
    );

    rx_regmap u_regmap (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .phase_i          (phase),
        .inc_acc_i        (inc_acc),
        .last_sample_i    (last_sample),
        .n_id_2_i         (n_id_2_q),
        .n_id_i           (n_id_q),
        .ibar_i           (ibar_q),
        .n_id_2_cnt_i     (n_id_2_cnt),
        .n_id_cnt_i       (n_id_cnt),
        .ibar_cnt_i       (ibar_cnt),
        .cfo_mode_o       (cfo_mode)
    );

endmodule

`default_nettype wire

// ==== logic/rx_regmap.sv ====
`default_nettype none

`include "rx_sync_defs.svh"

module rx_regmap
    import rx_sync_pkg::*;
    import rx_axil_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_ni,

    // write address / data / response
    input  wire axil_addr_t s_axil_awaddr_i,
    input  wire logic       s_axil_awvalid_i,
    output logic            s_axil_awready_o,
    input  wire axil_data_t s_axil_wdata_i,
    input  wire axil_strb_t s_axil_wstrb_i,
    input  wire logic       s_axil_wvalid_i,
    output logic            s_axil_wready_o,
    output axil_resp_t      s_axil_bresp_o,
    output logic            s_axil_bvalid_o,
    input  wire logic       s_axil_bready_i,

    // read address / data
    input  wire axil_addr_t s_axil_araddr_i,
    input  wire logic       s_axil_arvalid_i,
    output logic            s_axil_arready_o,
    output axil_data_t      s_axil_rdata_o,
    output axil_resp_t      s_axil_rresp_o,
    output logic            s_axil_rvalid_o,
    input  wire logic       s_axil_rready_i,

    // tracker and captures
    input  wire phase_t     phase_i,
    input  wire phase_t     inc_acc_i,
    input  wire sample_t    last_sample_i,
    input  wire n_id_2_t    n_id_2_i,
    input  wire n_id_t      n_id_i,
    input  wire ibar_t      ibar_i,
    input  wire cnt_t       n_id_2_cnt_i,
    input  wire cnt_t       n_id_cnt_i,
    input  wire cnt_t       ibar_cnt_i,

    output logic            cfo_mode_o
);

    logic       aw_ready_q;
    logic       b_valid_q;
    logic       ar_ready_q;
    logic       r_valid_q;
    axil_data_t r_data_q;
    logic       cfo_mode_q;
    logic       wr_fire;
    logic       rd_fire;
    reg_idx_t   ar_idx;
    axil_data_t rd_mux;

    // --------------------------------------------------
    // write path
    // --------------------------------------------------
    assign wr_fire = aw_ready_q && s_axil_awvalid_i && s_axil_wvalid_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            aw_ready_q <= 1'b0;
            b_valid_q  <= 1'b0;
            cfo_mode_q <= 1'b0;
        end else begin
            // one cycle accept, only with no response outstanding
            aw_ready_q <= s_axil_awvalid_i && s_axil_wvalid_i && !b_valid_q && !aw_ready_q;
            if (wr_fire) begin
                b_valid_q <= 1'b1;
                // only CTRL is writable
                if (s_axil_awaddr_i == `RX_REG_CTRL) begin
                    cfo_mode_q <= s_axil_wdata_i[0];
                end
            end else if (s_axil_bready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // read path
    // --------------------------------------------------
    assign rd_fire = ar_ready_q && s_axil_arvalid_i;
    assign ar_idx  = s_axil_araddr_i[4:2];

    always_comb begin
        rd_mux = '0;
        if (s_axil_araddr_i[`RX_AXIL_ADDR_W-1:5] == '0) begin
            case (ar_idx)
                reg_idx_t'(`RX_REG_ID >> 2):     rd_mux = `RX_ID;
                reg_idx_t'(`RX_REG_CTRL >> 2):   rd_mux = {31'b0, cfo_mode_q};
                reg_idx_t'(`RX_REG_SAMPLE >> 2): rd_mux = last_sample_i;
                reg_idx_t'(`RX_REG_PHASE >> 2):
                    rd_mux = {{(`RX_AXIL_DATA_W-`RX_PHASE_DW){phase_i[`RX_PHASE_DW-1]}}, phase_i};
                reg_idx_t'(`RX_REG_INC >> 2):
                    rd_mux = {{(`RX_AXIL_DATA_W-`RX_PHASE_DW){inc_acc_i[`RX_PHASE_DW-1]}},
                              inc_acc_i};
                // count on top, value at bit 0
                reg_idx_t'(`RX_REG_NID2 >> 2):
                    rd_mux = {n_id_2_cnt_i,
                              {(`RX_AXIL_DATA_W-`RX_CNT_W-$bits(n_id_2_t)){1'b0}}, n_id_2_i};
                reg_idx_t'(`RX_REG_NID >> 2):
                    rd_mux = {n_id_cnt_i,
                              {(`RX_AXIL_DATA_W-`RX_CNT_W-$bits(n_id_t)){1'b0}}, n_id_i};
                default:
                    rd_mux = {ibar_cnt_i,
                              {(`RX_AXIL_DATA_W-`RX_CNT_W-$bits(ibar_t)){1'b0}}, ibar_i};
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else if (rd_fire) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b1;
        end else if (r_valid_q && s_axil_rready_i) begin
            ar_ready_q <= 1'b1;
            r_valid_q  <= 1'b0;
        end else begin
            ar_ready_q <= !r_valid_q;
        end
    end

    // data taken at the address handshake
    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            r_data_q <= rd_mux;
        end
    end

    assign s_axil_awready_o = aw_ready_q;
    assign s_axil_wready_o  = aw_ready_q;
    assign s_axil_bvalid_o  = b_valid_q;
    assign s_axil_bresp_o   = RESP_OKAY;
    assign s_axil_arready_o = ar_ready_q;
    assign s_axil_rvalid_o  = r_valid_q;
    assign s_axil_rdata_o   = r_data_q;
    assign s_axil_rresp_o   = RESP_OKAY;
    assign cfo_mode_o       = cfo_mode_q;

endmodule

`default_nettype wire

// ==== logic/detect_capture.sv ====
`default_nettype none

module detect_capture
    import rx_sync_pkg::*;
#(
    parameter type payload_t = logic
)
(
    input  wire logic     clk_i,
    input  wire logic     reset_ni,

    input  wire payload_t value_i,
    input  wire logic     valid_i,

    output payload_t      value_o,
    output cnt_t          count_o
);

    payload_t value_q;
    cnt_t     count_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            value_q <= '0;
            count_q <= '0;
        end else if (valid_i) begin
            value_q <= value_i;
            // stick at all ones
            if (count_q != '1) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign value_o = value_q;
    assign count_o = count_q;

endmodule

`default_nettype wire

// ==== logic/cfo_phase_tracker.sv ====
`default_nettype none

module cfo_phase_tracker
    import rx_sync_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    reset_ni,

    input  wire sample_t sample_i,
    input  wire logic    sample_valid_i,

    input  wire phase_t  cfo_inc_i,
    input  wire logic    cfo_valid_i,

    input  wire logic    cfo_mode_i,

    output phase_t       phase_o,
    output phase_t       inc_acc_o,
    output sample_t      last_sample_o
);

    phase_t  phase_q;
    phase_t  inc_acc_q;
    sample_t last_sample_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q       <= '0;
            inc_acc_q     <= '0;
            last_sample_q <= '0;
        end else begin
            if (cfo_mode_i) begin
                // manual CFO, oscillator parked at zero
                inc_acc_q <= '0;
                phase_q   <= '0;
            end else begin
                // corrections are relative to the previous one
                if (cfo_valid_i) begin
                    inc_acc_q <= inc_acc_q - cfo_inc_i;
                end
                // old increment, wraps at 20 bits
                if (sample_valid_i) begin
                    phase_q <= phase_q + inc_acc_q;
                end
            end
            if (sample_valid_i) begin
                last_sample_q <= sample_i;
            end
        end
    end

    assign phase_o       = phase_q;
    assign inc_acc_o     = inc_acc_q;
    assign last_sample_o = last_sample_q;

endmodule

`default_nettype wire

// ==== logic/rx_axil_pkg.sv ====
`default_nettype none

`include "rx_sync_defs.svh"

package rx_axil_pkg;

    // --------------------------------------------------
    // AXI4-Lite channel payloads
    // --------------------------------------------------
    typedef logic [`RX_AXIL_ADDR_W-1:0]   axil_addr_t;
    typedef logic [`RX_AXIL_DATA_W-1:0]   axil_data_t;
    typedef logic [`RX_AXIL_DATA_W/8-1:0] axil_strb_t;
    typedef logic [1:0]                   axil_resp_t;

    localparam axil_resp_t RESP_OKAY = 2'b00;

    // --------------------------------------------------
    // register index
    // --------------------------------------------------
    // byte offset without the two low bits
    typedef logic [2:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== logic/rx_sync_pkg.sv ====
`default_nettype none

`include "rx_sync_defs.svh"

package rx_sync_pkg;

    // one received sample, Q in the upper half
    typedef logic [`RX_IN_DW-1:0] sample_t;

    // oscillator phase and phase increment
    typedef logic signed [`RX_PHASE_DW-1:0] phase_t;

    // PSS sector
    typedef logic [1:0] n_id_2_t;

    // physical cell identity, 0 to 1007
    typedef logic [9:0] n_id_t;

    // SSB index
    typedef logic [2:0] ibar_t;

    // saturating detection count
    typedef logic [`RX_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

// ==== include/rx_sync_defs.svh ====
`ifndef RX_SYNC_DEFS_SVH
`define RX_SYNC_DEFS_SVH

// --------------------------------------------------
// signal path widths
// --------------------------------------------------
// packed I/Q, 16 bits each
`define RX_IN_DW        32
`define RX_PHASE_DW     20
`define RX_CNT_W        16

// --------------------------------------------------
// register bus
// --------------------------------------------------
`define RX_AXIL_ADDR_W  8
`define RX_AXIL_DATA_W  32
`define RX_ID           32'h5253_0001

// byte offsets
`define RX_REG_ID       8'h00
`define RX_REG_CTRL     8'h04
`define RX_REG_SAMPLE   8'h08
`define RX_REG_PHASE    8'h0C
`define RX_REG_INC      8'h10
`define RX_REG_NID2     8'h14
`define RX_REG_NID      8'h18
`define RX_REG_IBAR     8'h1C

`endif
